// File: Makefile
TOOL       = verilator
TOP        = tb_mips_core
FILELIST   = sources.f
LINT_FLAGS = --lint-only -Wall --timing --assert
SIM_FLAGS  = --binary --assert -j 0
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hdl/alu.sv
`timescale 1ns/100ps

module alu import mips_pkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  alu_op_t op,
    output word_t   result,
    output logic    zero
);

    logic lt_signed;

    assign lt_signed = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            alu_add: result = a + b;               // wraps, no overflow trap
            alu_sub: result = a - b;
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_slt: result = {31'd0, lt_signed};
            default: result = '0;
        endcase
    end

    assign zero = (result == '0);                  // beq compare

endmodule

// File: hdl/data_access.sv
`timescale 1ns/100ps

module data_access import mips_pkg::*; (
    input  logic     clk,
    input  logic     rst_b,
    input  logic     mem_start,
    input  logic     mem_is_store,
    input  word_t    mem_addr,
    input  word_t    mem_wdata,
    input  mem_rsp_t data_rsp,
    output mem_req_t data_req,
    output logic     load_done,
    output word_t    load_data
);

    logic  req_valid, req_write;
    word_t req_addr, req_wdata;                  // held until done

    always_ff @(posedge clk) begin
        if (!rst_b) begin
            req_valid <= 1'b0;
            req_write <= 1'b0;
        end else if (mem_start) begin
            req_valid <= 1'b1;
            req_write <= mem_is_store;
            req_addr  <= mem_addr;
            req_wdata <= mem_wdata;
        end else if (data_rsp.done) begin
            req_valid <= 1'b0;
        end
    end

    always_comb begin
        data_req.valid = req_valid;
        data_req.write = req_write;
        data_req.addr  = req_addr;
        data_req.wdata = req_wdata;
    end

    assign load_done = data_rsp.done && req_valid; // stores pulse too
    assign load_data = data_rsp.rdata;

    a_no_overlap: assert property (@(posedge clk) disable iff (!rst_b)
        mem_start |-> !req_valid);

endmodule

// File: hdl/decoder.sv
`timescale 1ns/100ps

module decoder import mips_pkg::*; (
    input  word_t inst,
    output ctrl_t ctrl
);

    logic [5:0] opcode, funct;

    assign opcode = inst[31:26];
    assign funct  = inst[5:0];

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = alu_add;
        case (opcode)
            op_special: begin
                ctrl.reg_write = 1'b1;
                ctrl.dest      = inst[15:11];     // rd
                case (funct)
                    fn_addu:    ctrl.alu_op = alu_add;
                    fn_subu:    ctrl.alu_op = alu_sub;
                    fn_and:     ctrl.alu_op = alu_and;
                    fn_or:      ctrl.alu_op = alu_or;
                    fn_slt:     ctrl.alu_op = alu_slt;
                    fn_syscall: begin
                        ctrl.reg_write = 1'b0;
                        ctrl.halt      = 1'b1;
                    end
                    default: begin
                        ctrl.reg_write = 1'b0;
                        ctrl.illegal   = 1'b1; // unsupported funct
                    end
                endcase
            end
            op_addiu: begin
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.dest      = inst[20:16];     // rt
            end
            op_lw: begin
                ctrl.alu_src   = 1'b1;            // base + offset
                ctrl.reg_write = 1'b1;
                ctrl.dest      = inst[20:16];
                ctrl.mem_read  = 1'b1;
            end
            op_sw: begin
                ctrl.alu_src   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            op_beq: begin
                ctrl.alu_op = alu_sub;            // zero flag means equal
                ctrl.branch = 1'b1;
            end
            op_j:    ctrl.jump    = 1'b1;
            default: ctrl.illegal = 1'b1;
        endcase
    end

endmodule

// File: hdl/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit import mips_pkg::*; (
    input  logic     clk,
    input  logic     rst_b,
    input  mem_rsp_t fetch_rsp,
    input  ctrl_t    ctrl,
    input  word_t    alu_result,
    input  logic     zero,
    input  word_t    rs_data,
    input  word_t    rt_data,
    input  logic     load_done,
    input  word_t    load_data,
    output mem_req_t fetch_req,
    output word_t    inst,
    output reg_idx_t rs_num,
    output reg_idx_t rt_num,
    output word_t    alu_a,
    output word_t    alu_b,
    output logic     mem_start,
    output word_t    mem_addr,
    output word_t    mem_wdata,
    output logic     mem_is_store,
    output logic     rd_we,
    output reg_idx_t rd_num,
    output word_t    rd_data,
    output logic     halted
);

    typedef enum logic [1:0] {st_fetch, st_exec, st_mem, st_halt} fstate_t;

    fstate_t state;
    word_t   pc;
    logic    req_valid, req_is_pf;      // outstanding fetch, prefetch flag
    word_t   req_addr;
    logic    pf_valid;                  // one-entry prefetch buffer
    word_t   pf_addr, pf_data;
    word_t   pc_plus4, imm_sext, pc_next;
    logic    is_mem, pf_hit;

    assign pc_plus4 = pc + 32'd4;
    assign imm_sext = {{16{inst[15]}}, inst[15:0]};
    assign is_mem   = ctrl.mem_read | ctrl.mem_write;
    assign pf_hit   = pf_valid && (pf_addr == pc); // tag match against pc

    always_comb begin
        if (ctrl.jump)
            pc_next = {pc_plus4[31:28], inst[25:0], 2'b00};
        else if (ctrl.branch && zero)
            pc_next = pc_plus4 + (imm_sext << 2);
        else
            pc_next = pc_plus4;
    end

    always_comb begin
        fetch_req.valid = req_valid;
        fetch_req.write = 1'b0;                  // fetches only read
        fetch_req.addr  = req_addr;
        fetch_req.wdata = '0;
    end

    assign rs_num       = inst[25:21];
    assign rt_num       = inst[20:16];
    assign alu_a        = rs_data;
    assign alu_b        = ctrl.alu_src ? imm_sext : rt_data;
    assign mem_start    = (state == st_exec) && is_mem; // one-cycle start pulse
    assign mem_addr     = alu_result;
    assign mem_wdata    = rt_data;
    assign mem_is_store = ctrl.mem_write;
    assign rd_num       = ctrl.dest;
    assign rd_data      = ctrl.mem_read ? load_data : alu_result;
    assign rd_we        = ((state == st_exec) && ctrl.reg_write && !ctrl.mem_read) ||
                          ((state == st_mem) && load_done && ctrl.reg_write);
    assign halted       = (state == st_halt);

    always_ff @(posedge clk) begin
        if (!rst_b) begin
            state     <= st_fetch;
            pc        <= '0;
            req_valid <= 1'b0;
            req_is_pf <= 1'b0;
            pf_valid  <= 1'b0;
        end else begin
            if (fetch_rsp.done) begin
                req_valid <= 1'b0;
                if (req_is_pf) begin            // fill the tagged buffer
                    pf_valid <= 1'b1;
                    pf_addr  <= req_addr;
                    pf_data  <= fetch_rsp.rdata;
                end else begin
                    inst  <= fetch_rsp.rdata;
                    state <= st_exec;
                end
            end
            case (state)
                st_fetch: begin
                    if (pf_hit) begin           // skip the fetch transfer
                        inst     <= pf_data;
                        pf_valid <= 1'b0;
                        state    <= st_exec;
                    end else if (!req_valid) begin
                        req_valid <= 1'b1;
                        req_addr  <= pc;
                        req_is_pf <= 1'b0;
                        pf_valid  <= 1'b0;      // stale entry goes
                    end
                end
                st_exec: begin
                    if (ctrl.halt || ctrl.illegal) begin
                        state <= st_halt;
                    end else if (is_mem) begin
                        state <= st_mem;
                        if (!req_valid && !pf_valid) begin // prefetch pc+4
                            req_valid <= 1'b1;
                            req_addr  <= pc_plus4;
                            req_is_pf <= 1'b1;
                        end
                    end else begin
                        pc    <= pc_next;
                        state <= st_fetch;
                        if (pc_next != pc_plus4)
                            pf_valid <= 1'b0;   // redirect drops the prefetch
                    end
                end
                st_mem: begin
                    if (load_done) begin        // lw and sw never redirect
                        pc    <= pc_plus4;
                        state <= st_fetch;
                    end
                end
                default: ;                      // halted until reset
            endcase
        end
    end

    // a write to r0 must not show up on a later read of r0
    a_r0_zero: assert property (@(posedge clk) disable iff (!rst_b)
        (rd_we && rd_num == 5'd0) |=> (rs_num != 5'd0 || rs_data == '0));

    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_b)
        (state != st_halt) |-> (pc[1:0] == 2'b00 && (!req_valid || req_addr[1:0] == 2'b00)));

endmodule

// File: hdl/mem_arbiter.sv
`timescale 1ns/100ps

module mem_arbiter import mips_pkg::*; (
    input  logic     clk,
    input  logic     rst_b,
    input  mem_req_t data_req,
    input  mem_req_t fetch_req,
    output mem_rsp_t data_rsp,
    output mem_rsp_t fetch_rsp,
    output apb_req_t apb_out,
    input  apb_rsp_t apb_in
);

    typedef enum logic [1:0] {ar_idle, ar_setup, ar_access} astate_t;

    astate_t  state;
    logic     owner_data;                        // high when data_access owns the grant
    mem_req_t sel_req;
    logic     xfer_done;

    assign sel_req   = owner_data ? data_req : fetch_req;
    assign xfer_done = (state == ar_access) && apb_in.pready;

    always_ff @(posedge clk) begin
        if (!rst_b) begin
            state      <= ar_idle;
            owner_data <= 1'b0;
        end else begin
            case (state)
                ar_idle: if (data_req.valid || fetch_req.valid) begin
                    owner_data <= data_req.valid; // data wins a tie
                    state      <= ar_setup;
                end
                ar_setup:  state <= ar_access;
                ar_access: if (apb_in.pready) state <= ar_idle;
                default:   state <= ar_idle;
            endcase
        end
    end

    always_comb begin
        apb_out.psel    = (state != ar_idle);
        apb_out.penable = (state == ar_access);
        apb_out.pwrite  = apb_out.psel && sel_req.write;
        apb_out.paddr   = sel_req.addr;
        apb_out.pwdata  = sel_req.wdata;
        data_rsp.done   = xfer_done && owner_data;  // only the owner sees done
        data_rsp.rdata  = owner_data ? apb_in.prdata : '0;
        fetch_rsp.done  = xfer_done && !owner_data;
        fetch_rsp.rdata = owner_data ? '0 : apb_in.prdata;
    end

    a_paddr_stable: assert property (@(posedge clk) disable iff (!rst_b)
        (apb_out.psel && !xfer_done) |=> $stable(apb_out.paddr));

    // setup must carry a live request from the granted owner
    a_setup_first: assert property (@(posedge clk) disable iff (!rst_b)
        $rose(apb_out.penable) |->
            $past(apb_out.psel && !apb_out.penable && sel_req.valid));

endmodule

// File: hdl/mips_core.sv
`timescale 1ns/100ps

module mips_core import mips_pkg::*; (
    input  logic     clk,
    input  logic     rst_b,
    output apb_req_t apb_out,
    input  apb_rsp_t apb_in,
    output logic     halted
);

    mem_req_t fetch_req, data_req;   // requester side of the arbiter
    mem_rsp_t fetch_rsp, data_rsp;
    word_t    inst;
    ctrl_t    ctrl;
    reg_idx_t rs_num, rt_num, rd_num;
    word_t    rs_data, rt_data, rd_data;
    logic     rd_we;
    word_t    alu_a, alu_b, alu_result;
    logic     zero;
    logic     mem_start, mem_is_store, load_done;
    word_t    mem_addr, mem_wdata, load_data;

    fetch_unit fetch_unit0 (
        .clk, .rst_b,
        .fetch_rsp, .ctrl, .alu_result, .zero, .rs_data, .rt_data,
        .load_done, .load_data,
        .fetch_req, .inst, .rs_num, .rt_num, .alu_a, .alu_b,
        .mem_start, .mem_addr, .mem_wdata, .mem_is_store,
        .rd_we, .rd_num, .rd_data, .halted
    );

    decoder decoder0 (.inst, .ctrl);

    alu alu0 (.a(alu_a), .b(alu_b), .op(ctrl.alu_op), .result(alu_result), .zero);

    regfile regfile0 (
        .clk, .rst_b,
        .rs_num, .rt_num, .rd_num, .rd_data, .rd_we,
        .rs_data, .rt_data
    );

    data_access data_access0 (
        .clk, .rst_b,
        .mem_start, .mem_is_store, .mem_addr, .mem_wdata,
        .data_rsp, .data_req, .load_done, .load_data
    );

    mem_arbiter mem_arbiter0 (
        .clk, .rst_b,
        .data_req, .fetch_req, .data_rsp, .fetch_rsp,
        .apb_out, .apb_in
    );

endmodule

// File: hdl/mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] word_t;    // data and address word
    typedef logic [4:0]  reg_idx_t; // register number

    // primary opcodes, inst[31:26]
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    // function codes for op_special, inst[5:0]
    localparam logic [5:0] fn_syscall = 6'h0c;
    localparam logic [5:0] fn_addu    = 6'h21;
    localparam logic [5:0] fn_subu    = 6'h23;
    localparam logic [5:0] fn_and     = 6'h24;
    localparam logic [5:0] fn_or      = 6'h25;
    localparam logic [5:0] fn_slt     = 6'h2a;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt
    } alu_op_t;

    typedef struct packed {
        alu_op_t  alu_op;
        logic     alu_src;   // sign-extended immediate replaces rt
        logic     reg_write;
        reg_idx_t dest;      // rd for r-type, rt for addiu and lw
        logic     mem_read;
        logic     mem_write;
        logic     branch;
        logic     jump;
        logic     halt;
        logic     illegal;
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        logic  write;
        word_t addr;
        word_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic  done;  // one-cycle pulse
        word_t rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic  psel;
        logic  penable;
        logic  pwrite;
        word_t paddr;
        word_t pwdata;
    } apb_req_t;

    typedef struct packed {
        word_t prdata;
        logic  pready;
    } apb_rsp_t;

endpackage

// File: hdl/regfile.sv
`timescale 1ns/100ps

module regfile import mips_pkg::*; (
    input  logic     clk,
    input  logic     rst_b,
    input  reg_idx_t rs_num,
    input  reg_idx_t rt_num,
    input  reg_idx_t rd_num,
    input  word_t    rd_data,
    input  logic     rd_we,
    output word_t    rs_data,
    output word_t    rt_data
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (!rst_b) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;                     // all registers clear
        end else if (rd_we && rd_num != 5'd0) begin
            regs[rd_num] <= rd_data;
        end
    end

    // async reads, r0 hardwired
    assign rs_data = (rs_num == 5'd0) ? '0 : regs[rs_num];
    assign rt_data = (rt_num == 5'd0) ? '0 : regs[rt_num];

endmodule

// File: sources.f
hdl/mips_pkg.sv
hdl/alu.sv
hdl/decoder.sv
hdl/regfile.sv
hdl/data_access.sv
hdl/mem_arbiter.sv
hdl/fetch_unit.sv
hdl/mips_core.sv
verif/tb_clock_gen.sv
verif/tb_mips_core.sv

// File: verif/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic rst_b
);

    initial begin
        clk   = 1'b0;
        rst_b = 1'b0;                  // reset low from time 0
        repeat (3) @(negedge clk);     // covers three rising edges
        rst_b = 1'b1;                  // released on a falling edge
    end

    always #50 clk = ~clk;             // 100 ns period

endmodule

// File: verif/tb_mips_core.sv
`timescale 1ns/100ps

module tb_mips_core import mips_pkg::*; ();

    // 40 instr * (2 transfers * 4 cycles + 1) = 360 cycles, so ample margin
    localparam int    max_cycles = 3000;
    localparam int    exp_stores = 10;              // sw on the executed path
    localparam word_t a_val      = 32'd7;
    localparam word_t b_val      = 32'hffff_fffd;   // -3
    localparam word_t ld_val     = 32'h1234_5678;   // preloaded at 0x200
    localparam word_t marker     = 32'h0000_0bad;   // only on skipped paths

    logic     clk, rst_b, halted;
    apb_req_t apb_out;
    apb_rsp_t apb_in;
    word_t    mem [256];                            // 1 KB shared memory
    int       seed, wait_left, xfer_count, store_count, cycles, errors;
    logic     wr_done;

    tb_clock_gen clock_gen0 (.clk, .rst_b);

    mips_core dut0 (.clk, .rst_b, .apb_out, .apb_in, .halted);

    function automatic word_t r_type(logic [5:0] funct, reg_idx_t rd, reg_idx_t rs,
                                     reg_idx_t rt);
        return {op_special, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic word_t i_type(logic [5:0] op, reg_idx_t rs, reg_idx_t rt,
                                     logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t j_type(logic [25:0] target);
        return {op_j, target};                      // word index of the target
    endfunction

    function automatic logic is_result(word_t addr);
        return addr >= 32'h300 && addr <= 32'h324 && addr[1:0] == 2'b00;
    endfunction

    function automatic word_t expected_store(word_t addr);
        case (addr)
            32'h300: return a_val + b_val;          // addu wraps
            32'h304: return a_val - b_val;
            32'h308: return a_val & b_val;
            32'h30c: return a_val | b_val;
            32'h310: return ($signed(b_val) < $signed(a_val)) ? 32'd1 : 32'd0;
            32'h314: return ($signed(a_val) < $signed(b_val)) ? 32'd1 : 32'd0;
            32'h318: return a_val;                  // plain addiu
            32'h31c: return ld_val + 32'h55;        // load reaches write-back
            32'h320: return a_val;                  // beq fell through
            default: return 32'd0;                  // r0 stays zero
        endcase
    endfunction

    function automatic string store_name(word_t addr);
        case (addr)
            32'h300: return "addu";
            32'h304: return "subu";
            32'h308: return "and";
            32'h30c: return "or";
            32'h310: return "slt_true";
            32'h314: return "slt_false";
            32'h318: return "addiu";
            32'h31c: return "load_add";
            32'h320: return "beq_not_taken";
            default: return "reg_zero";
        endcase
    endfunction

    task automatic load_program();
        for (int i = 0; i < 256; i++)
            mem[i] = 32'ha500_0000 + i;             // decodes as illegal
        mem[128] = ld_val;
        mem[0]  = i_type(op_addiu, 5'd0, 5'd1, 16'd7);
        mem[1]  = i_type(op_addiu, 5'd0, 5'd2, 16'hfffd);
        mem[2]  = i_type(op_addiu, 5'd0, 5'd12, 16'h0bad);
        mem[3]  = r_type(fn_addu, 5'd3, 5'd1, 5'd2);
        mem[4]  = r_type(fn_subu, 5'd4, 5'd1, 5'd2);
        mem[5]  = r_type(fn_and, 5'd5, 5'd1, 5'd2);
        mem[6]  = r_type(fn_or, 5'd6, 5'd1, 5'd2);
        mem[7]  = r_type(fn_slt, 5'd7, 5'd2, 5'd1); // -3 < 7
        mem[8]  = r_type(fn_slt, 5'd8, 5'd1, 5'd2); // 7 < -3
        mem[9]  = i_type(op_sw, 5'd0, 5'd3, 16'h0300);
        mem[10] = i_type(op_sw, 5'd0, 5'd4, 16'h0304);
        mem[11] = i_type(op_sw, 5'd0, 5'd5, 16'h0308);
        mem[12] = i_type(op_sw, 5'd0, 5'd6, 16'h030c);
        mem[13] = i_type(op_sw, 5'd0, 5'd7, 16'h0310);
        mem[14] = i_type(op_sw, 5'd0, 5'd8, 16'h0314);
        mem[15] = i_type(op_sw, 5'd0, 5'd1, 16'h0318);
        mem[16] = i_type(op_lw, 5'd0, 5'd9, 16'h0200);
        mem[17] = i_type(op_addiu, 5'd9, 5'd10, 16'h0055);
        mem[18] = i_type(op_sw, 5'd0, 5'd10, 16'h031c);
        mem[19] = i_type(op_beq, 5'd1, 5'd1, 16'd1);  // taken, to 21
        mem[20] = i_type(op_sw, 5'd0, 5'd12, 16'h03f0);
        mem[21] = j_type(26'd23);
        mem[22] = i_type(op_sw, 5'd0, 5'd12, 16'h03f0);
        mem[23] = i_type(op_beq, 5'd1, 5'd2, 16'd1);  // not taken
        mem[24] = i_type(op_sw, 5'd0, 5'd1, 16'h0320);
        mem[25] = i_type(op_addiu, 5'd0, 5'd0, 16'h1234);
        mem[26] = i_type(op_sw, 5'd0, 5'd0, 16'h0324);
        mem[27] = r_type(fn_syscall, 5'd0, 5'd0, 5'd0);
    endtask

    // APB slave, 0 to 2 wait states per transfer
    always @(negedge clk) begin
        if (!rst_b) begin
            apb_in.pready = 1'b0;
        end else if (apb_out.psel && !apb_out.penable) begin
            wait_left     = {$random(seed)} % 3;    // setup picks the wait count
            apb_in.pready = 1'b0;
            xfer_count++;
        end else if (apb_out.psel && apb_out.penable) begin
            if (wait_left == 0) begin
                apb_in.pready = 1'b1;               // ends on the next rising edge
                if (apb_out.pwrite) begin
                    mem[apb_out.paddr[9:2]] = apb_out.pwdata;
                    store_count++;
                end else begin
                    apb_in.prdata = mem[apb_out.paddr[9:2]];
                end
            end else begin
                wait_left--;
            end
        end else begin
            apb_in.pready = 1'b0;
        end
    end

    assign wr_done = apb_out.psel && apb_out.penable && apb_in.pready && apb_out.pwrite;

    a_store_value: assert property (@(posedge clk) disable iff (!rst_b)
        (wr_done && is_result(apb_out.paddr)) |->
            apb_out.pwdata == expected_store(apb_out.paddr))
        else begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", store_name($sampled(apb_out.paddr)),
                     expected_store($sampled(apb_out.paddr)), $sampled(apb_out.pwdata));
        end

    a_no_marker: assert property (@(posedge clk) disable iff (!rst_b)
        wr_done |-> apb_out.pwdata != marker)
        else begin
            errors++;
            $display("FAILED skip_marker: expected not %h, actual %h", marker,
                     $sampled(apb_out.pwdata));
        end

    a_store_addr: assert property (@(posedge clk) disable iff (!rst_b)
        wr_done |-> is_result(apb_out.paddr))
        else begin
            errors++;
            $display("ERROR: store to unexpected address %h", $sampled(apb_out.paddr));
        end

    a_setup_access: assert property (@(posedge clk) disable iff (!rst_b)
        (apb_out.psel && !apb_out.penable) |=> (apb_out.psel && apb_out.penable))
        else begin
            errors++;
            $display("ERROR: setup cycle not followed by an access cycle at %0t", $time);
        end

    // paddr and pwrite hold from setup until pready
    a_addr_stable: assert property (@(posedge clk) disable iff (!rst_b)
        (apb_out.psel && !(apb_out.penable && apb_in.pready)) |=>
            ($stable(apb_out.paddr) && $stable(apb_out.pwrite)))
        else begin
            errors++;
            $display("ERROR: paddr or pwrite changed before pready at %0t", $time);
        end

    a_read_aligned: assert property (@(posedge clk) disable iff (!rst_b)
        (apb_out.psel && !apb_out.pwrite) |-> apb_out.paddr[1:0] == 2'b00)
        else begin
            errors++;
            $display("ERROR: unaligned read at %h", $sampled(apb_out.paddr));
        end

    a_first_fetch: assert property (@(posedge clk) disable iff (!rst_b)
        (apb_out.psel && !apb_out.penable && xfer_count == 1) |->
            (!apb_out.pwrite && apb_out.paddr == 32'd0))
        else begin
            errors++;
            $display("FAILED first_fetch: expected %h, actual %h", 32'd0,
                     $sampled(apb_out.paddr));
        end

    a_halt_quiet: assert property (@(posedge clk) disable iff (!rst_b)
        halted |-> !apb_out.psel)
        else begin
            errors++;
            $display("ERROR: bus request after halt at %0t", $time);
        end

    a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_b)
        halted |=> halted)
        else begin
            errors++;
            $display("ERROR: halted dropped before reset at %0t", $time);
        end

    initial begin
        seed        = 7877;
        wait_left   = 0;
        xfer_count  = 0;
        store_count = 0;
        cycles      = 0;
        errors      = 0;
        apb_in      = '0;
        load_program();
        @(posedge rst_b);
        while (!halted && cycles < max_cycles) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            errors++;
            $display("ERROR: halted never rose within %0d cycles", max_cycles);
        end else begin
            repeat (10) @(negedge clk);             // bus must stay idle
        end
        a_store_count: assert (store_count == exp_stores)
            else begin
                errors++;
                $display("FAILED store_count: expected %0d, actual %0d", exp_stores,
                         store_count);
            end
        $display("errors: %0d, stores: %0d, cycles: %0d", errors, store_count, cycles);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
